// File: program.hex
// one 64-bit fetch word per line, upper instruction then lower instruction
00208113_00100093
00418213_00310193
00628313_00520293
00838413_00730393
00a48513_00940493
00c58613_00b50593
00e68713_00d60693
01078813_00f70793
01288913_01180893
01498a13_01390993
016a8b13_015a0a93
018b8c13_017b0b93
01ac8d13_019c0c93
01cd8e13_01bd0d93
01ee8f13_01de0e93
0000006f_fff00f13

// File: files.f
design/fetch_pkg.sv
design/mem_wait_timer.sv
design/instr_rom.sv
design/fetch_ctrl.sv
design/fetch_buffer.sv
design/btac.sv
design/fetch_unit.sv
tb/fetch_unit_props.sv
tb/fetch_unit_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = fetch_unit_tb
FILELIST  = files.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: tb/fetch_unit_tb.sv
`timescale 1ns/1ns

module fetch_unit_tb import fetch_pkg::*; ;

    localparam int planned        = 400;  // instructions to check
    localparam int seq_count      = 48;   // plain sequential stretch first
    localparam int timeout_cycles = planned * 40;
    localparam int btac_sets      = 8;
    localparam int set_bits       = $clog2(btac_sets);

    logic            clock;
    logic            reset;
    logic            halt;
    logic            trap;
    logic [xlen-1:0] mtvec;
    logic            mret;
    logic [xlen-1:0] mepc;
    logic            miss;
    logic [xlen-1:0] miss_addr;
    logic            fence;
    logic [xlen-1:0] fence_npc;
    logic            upd_valid;
    logic [xlen-1:0] upd_pc;
    logic            upd_taken;
    logic [xlen-1:0] upd_target;
    logic [xlen-1:0] pc0;
    logic [xlen-1:0] pc1;
    logic [ilen-1:0] instr0;
    logic [ilen-1:0] instr1;
    logic            ready0;
    logic            ready1;

    logic [fetch_width-1:0] rom_image [rom_words];
    logic [15:0]            lfsr;
    int                     burst_left;
    int                     checked;
    int                     since_reset;  // cycles since reset release
    logic [xlen-1:0]        expected_pc;

    // branch target model with one pc and target per set
    logic            model_valid  [btac_sets];
    logic [xlen-1:0] model_pc     [btac_sets];
    logic [xlen-1:0] model_target [btac_sets];

    // outputs of the previous cycle for the hold check
    logic            held_halt;
    logic            held_ext;
    logic            held_ready0;
    logic            held_ready1;
    logic [xlen-1:0] held_pc0;
    logic [xlen-1:0] held_pc1;
    logic [ilen-1:0] held_instr0;
    logic [ilen-1:0] held_instr1;

    fetch_unit #(
        .btac_entries(btac_sets)
    ) fetch_unit_inst (
        .clock     (clock),
        .reset     (reset),
        .halt      (halt),
        .trap      (trap),
        .mtvec     (mtvec),
        .mret      (mret),
        .mepc      (mepc),
        .miss      (miss),
        .miss_addr (miss_addr),
        .fence     (fence),
        .fence_npc (fence_npc),
        .upd_valid (upd_valid),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken),
        .upd_target(upd_target),
        .pc0       (pc0),
        .pc1       (pc1),
        .instr0    (instr0),
        .instr1    (instr1),
        .ready0    (ready0),
        .ready1    (ready1)
    );

    always #2 clock = ~clock;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // instruction at pc over the wrapping rom
    function automatic logic [ilen-1:0] expected_instr(input logic [xlen-1:0] pc);
        logic [fetch_width-1:0] word;
        word = rom_image[pc[6:3]];
        return pc[2] ? word[fetch_width-1:ilen] : word[ilen-1:0];
    endfunction

    function automatic logic btac_hit(input logic [xlen-1:0] pc);
        logic [set_bits-1:0] idx;
        idx = pc[set_bits+1:2];
        return model_valid[idx] && (model_pc[idx][xlen-1:2] == pc[xlen-1:2]);
    endfunction

    function automatic logic [xlen-1:0] btac_target(input logic [xlen-1:0] pc);
        return model_target[pc[set_bits+1:2]];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                   input logic [xlen-1:0] want);
        $display("** Error: %s = %h, expected %h", name, got, want);
        abort_run("value check failed");
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] kinds;
        logic [31:0] t;
        trap      <= 1'b0;
        mret      <= 1'b0;
        miss      <= 1'b0;
        fence     <= 1'b0;
        upd_valid <= 1'b0;
        if (checked < seq_count) begin
            halt <= 1'b0;
            return;
        end
        if (burst_left > 0) begin
            halt <= 1'b1;
            burst_left--;
        end else begin
            take_bits(3, r);
            if (r == 0) begin
                take_bits(3, r);
                burst_left = int'(r);
                halt <= 1'b1;
            end else begin
                halt <= 1'b0;
            end
        end
        take_bits(4, r);
        if (r == 0) begin  // any mix of the four sources
            take_bits(4, kinds);
            trap  <= kinds[0];
            mret  <= kinds[1];
            miss  <= kinds[2];
            fence <= kinds[3];
            take_bits(5, t);
            mtvec <= t << 2;
            take_bits(5, t);
            mepc <= t << 2;
            take_bits(5, t);
            miss_addr <= t << 2;
            take_bits(5, t);
            fence_npc <= t << 2;
        end
        take_bits(3, r);
        if (r == 0) begin
            upd_valid <= 1'b1;
            take_bits(5, t);
            upd_pc <= t << 2;
            take_bits(2, r);
            upd_taken <= (r != 0);
            take_bits(5, t);
            upd_target <= t << 2;
        end
    endtask

    // idle cycle, request cycle, then the wait states and the fill
    task automatic check_first_fill();
        int first_ready;
        first_ready = int'(fetch_unit_inst.mem_latency) + 4;
        if (since_reset <= first_ready) begin
            assert (ready0 == (since_reset == first_ready))
                else report_mismatch("ready0", xlen'(ready0),
                                     xlen'(since_reset == first_ready));
        end
    endtask

    task automatic check_hold();
        if (held_halt && !held_ext && held_ready0) begin
            assert (ready0) else report_mismatch("ready0", xlen'(ready0), 32'h1);
            assert (pc0 == held_pc0) else report_mismatch("pc0", pc0, held_pc0);
            assert (instr0 == held_instr0) else report_mismatch("instr0", instr0, held_instr0);
            if (held_ready1) begin
                assert (ready1) else report_mismatch("ready1", xlen'(ready1), 32'h1);
                assert (pc1 == held_pc1) else report_mismatch("pc1", pc1, held_pc1);
                assert (instr1 == held_instr1)
                    else report_mismatch("instr1", instr1, held_instr1);
            end
        end
    endtask

    task automatic consume_and_check();
        logic [xlen-1:0] next_pc;
        if (!halt && ready0) begin
            assert (pc0 == expected_pc) else report_mismatch("pc0", pc0, expected_pc);
            assert (instr0 == expected_instr(expected_pc))
                else report_mismatch("instr0", instr0, expected_instr(expected_pc));
            checked++;
            next_pc = expected_pc + 32'd4;
            if (btac_hit(expected_pc)) begin
                next_pc = btac_target(expected_pc);  // slot 1 is dropped by decode
            end else if (ready1) begin
                assert (pc1 == next_pc) else report_mismatch("pc1", pc1, next_pc);
                assert (instr1 == expected_instr(next_pc))
                    else report_mismatch("instr1", instr1, expected_instr(next_pc));
                checked++;
                next_pc = btac_hit(next_pc) ? btac_target(next_pc) : next_pc + 32'd4;
            end
            expected_pc = next_pc;
        end
        // outside sources override any prediction
        if (trap) begin
            expected_pc = mtvec;
        end else if (mret) begin
            expected_pc = mepc;
        end else if (miss) begin
            expected_pc = miss_addr;
        end else if (fence) begin
            expected_pc = fence_npc;
        end
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            expected_pc = fetch_unit_inst.reset_pc;
            held_halt   = 1'b0;
            since_reset = 0;
        end else begin
            since_reset++;
            check_first_fill();
            check_hold();
            consume_and_check();
            if (upd_valid) begin  // after the lookup so it counts from next cycle
                model_valid[upd_pc[set_bits+1:2]]  = upd_taken;
                model_pc[upd_pc[set_bits+1:2]]     = upd_pc;
                model_target[upd_pc[set_bits+1:2]] = upd_target;
            end
            held_halt   = halt;
            held_ext    = trap || mret || miss || fence;
            held_ready0 = ready0;
            held_ready1 = ready1;
            held_pc0    = pc0;
            held_pc1    = pc1;
            held_instr0 = instr0;
            held_instr1 = instr1;
        end
    end

    initial begin
        $readmemh("program.hex", rom_image);
        for (int i = 0; i < btac_sets; i++) begin
            model_valid[i] = 1'b0;
        end
        lfsr        = 16'd29478;
        burst_left  = 0;
        checked     = 0;
        since_reset = 0;
        clock       = 1'b0;
        reset       = 1'b0;
        halt        = 1'b0;
        trap        = 1'b0;
        mtvec       = '0;
        mret        = 1'b0;
        mepc        = '0;
        miss        = 1'b0;
        miss_addr   = '0;
        fence       = 1'b0;
        fence_npc   = '0;
        upd_valid   = 1'b0;
        upd_pc      = '0;
        upd_taken   = 1'b0;
        upd_target  = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        forever begin
            @(posedge clock);
            drive_inputs();
        end
    end

    initial begin
        wait (checked >= planned);
        @(posedge clock);
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        abort_run("watchdog expired before all planned instructions were checked");
    end

endmodule

// File: tb/fetch_unit_props.sv
`timescale 1ns/1ns

module fetch_unit_props (
    input logic clock,
    input logic reset,
    input logic mem_valid,
    input logic fill_valid,
    input logic flush,
    input logic full,
    input logic ready0
);

    // no request in the cycle after reset
    quiet_after_reset: assert property (@(posedge clock) !reset |=> !mem_valid)
        else $error("memory request right after reset");

    // room for a whole word was there at the request
    no_fill_when_full: assert property (
        @(posedge clock) disable iff (!reset) fill_valid |-> !full)
        else $error("memory response written into a full buffer");

    flush_empties: assert property (
        @(posedge clock) disable iff (!reset) flush |=> !ready0)
        else $error("buffer still presents instructions after a flush");

endmodule

bind fetch_unit fetch_unit_props props_inst (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .fill_valid(fill_valid),
    .flush     (flush),
    .full      (full),
    .ready0    (ready0)
);

// File: design/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit import fetch_pkg::*; #(
    parameter int unsigned     mem_latency  = 2,
    parameter int              btac_entries = 8,
    parameter logic [xlen-1:0] reset_pc     = '0
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            halt,
    input  logic            trap,
    input  logic [xlen-1:0] mtvec,
    input  logic            mret,
    input  logic [xlen-1:0] mepc,
    input  logic            miss,
    input  logic [xlen-1:0] miss_addr,
    input  logic            fence,
    input  logic [xlen-1:0] fence_npc,
    input  logic            upd_valid,
    input  logic [xlen-1:0] upd_pc,
    input  logic            upd_taken,
    input  logic [xlen-1:0] upd_target,
    output logic [xlen-1:0] pc0,
    output logic [xlen-1:0] pc1,
    output logic [ilen-1:0] instr0,
    output logic [ilen-1:0] instr1,
    output logic            ready0,
    output logic            ready1
);

    logic                   mem_valid;
    logic [xlen-1:0]        mem_addr;
    logic                   mem_ready;
    logic [fetch_width-1:0] mem_rdata;
    logic                   fill_valid;
    logic [xlen-1:0]        fill_pc;
    logic                   flush;
    logic                   full;
    logic                   pred0_taken;
    logic [xlen-1:0]        pred0_target;
    logic                   pred1_taken;
    logic [xlen-1:0]        pred1_target;

    fetch_ctrl #(
        .reset_pc(reset_pc)
    ) fetch_ctrl_inst (
        .clock       (clock),
        .reset       (reset),
        .trap        (trap),
        .mtvec       (mtvec),
        .mret        (mret),
        .mepc        (mepc),
        .miss        (miss),
        .miss_addr   (miss_addr),
        .fence       (fence),
        .fence_npc   (fence_npc),
        .pred0_taken (pred0_taken),
        .pred0_target(pred0_target),
        .pred1_taken (pred1_taken),
        .pred1_target(pred1_target),
        .mem_ready   (mem_ready),
        .full        (full),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .fill_valid  (fill_valid),
        .fill_pc     (fill_pc),
        .flush       (flush)
    );

    instr_rom #(
        .mem_latency(mem_latency)
    ) instr_rom_inst (
        .clock    (clock),
        .reset    (reset),
        .mem_valid(mem_valid),
        .mem_addr (mem_addr),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    fetch_buffer fetch_buffer_inst (
        .clock     (clock),
        .reset     (reset),
        .fill_valid(fill_valid),
        .fill_pc   (fill_pc),
        .fill_data (mem_rdata),
        .flush     (flush),
        .halt      (halt),
        .full      (full),
        .pc0       (pc0),
        .pc1       (pc1),
        .instr0    (instr0),
        .instr1    (instr1),
        .ready0    (ready0),
        .ready1    (ready1)
    );

    // only a pair that decode takes this cycle may redirect, a held pair would be flushed
    btac #(
        .btac_entries(btac_entries)
    ) btac_inst (
        .clock       (clock),
        .reset       (reset),
        .pc0         (pc0),
        .pc1         (pc1),
        .ready0      (ready0 && !halt),
        .ready1      (ready1 && !halt),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .upd_target  (upd_target),
        .pred0_taken (pred0_taken),
        .pred0_target(pred0_target),
        .pred1_taken (pred1_taken),
        .pred1_target(pred1_target)
    );

endmodule

// File: design/btac.sv
`timescale 1ns/1ns

module btac import fetch_pkg::*; #(
    parameter int btac_entries = 8
) (
    input  logic            clock,
    input  logic            reset,
    input  logic [xlen-1:0] pc0,
    input  logic [xlen-1:0] pc1,
    input  logic            ready0,
    input  logic            ready1,
    input  logic            upd_valid,
    input  logic [xlen-1:0] upd_pc,
    input  logic            upd_taken,
    input  logic [xlen-1:0] upd_target,
    output logic            pred0_taken,
    output logic [xlen-1:0] pred0_target,
    output logic            pred1_taken,
    output logic [xlen-1:0] pred1_target
);

    localparam int index_bits = $clog2(btac_entries);
    localparam int tag_bits   = xlen - index_bits - 2;

    logic [btac_entries-1:0] valid;
    logic [tag_bits-1:0]     tag_mem    [btac_entries];
    logic [xlen-1:0]         target_mem [btac_entries];
    logic [index_bits-1:0]   idx0;
    logic [index_bits-1:0]   idx1;
    logic [index_bits-1:0]   upd_idx;

    assign idx0    = pc0[index_bits+1:2];
    assign idx1    = pc1[index_bits+1:2];
    assign upd_idx = upd_pc[index_bits+1:2];

    assign pred0_taken  = ready0 && valid[idx0] && (tag_mem[idx0] == pc0[xlen-1:index_bits+2]);
    assign pred1_taken  = ready1 && valid[idx1] && (tag_mem[idx1] == pc1[xlen-1:index_bits+2]);
    assign pred0_target = target_mem[idx0];
    assign pred1_target = target_mem[idx1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            valid <= '0;
        end else if (upd_valid) begin
            valid[upd_idx] <= upd_taken;  // not taken drops the entry
        end
    end

    always_ff @(posedge clock) begin
        if (upd_valid && upd_taken) begin
            tag_mem[upd_idx]    <= upd_pc[xlen-1:index_bits+2];
            target_mem[upd_idx] <= upd_target;
        end
    end

endmodule

// File: design/fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer import fetch_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   fill_valid,
    input  logic [xlen-1:0]        fill_pc,
    input  logic [fetch_width-1:0] fill_data,
    input  logic                   flush,
    input  logic                   halt,
    output logic                   full,
    output logic [xlen-1:0]        pc0,
    output logic [xlen-1:0]        pc1,
    output logic [ilen-1:0]        instr0,
    output logic [ilen-1:0]        instr1,
    output logic                   ready0,
    output logic                   ready1
);

    localparam int slots = 4;

    logic [xlen-1:0] pc_q    [slots];
    logic [ilen-1:0] instr_q [slots];
    logic [1:0]      head;
    logic [1:0]      head1;
    logic [1:0]      tail;
    logic [1:0]      tail1;
    logic [2:0]      count;  // 0 to 4
    logic [1:0]      n_in;
    logic [1:0]      n_out;

    assign head1 = head + 2'd1;
    assign tail  = head + count[1:0];
    assign tail1 = tail + 2'd1;

    assign ready0 = count != 3'd0;
    assign ready1 = count > 3'd1;
    assign pc0    = pc_q[head];
    assign pc1    = pc_q[head1];
    assign instr0 = instr_q[head];
    assign instr1 = instr_q[head1];

    // room for a whole word must be there before a request goes out
    assign full = count > 3'd2;

    always_comb begin
        if (halt) begin
            n_out = 2'd0;
        end else if (ready1) begin
            n_out = 2'd2;
        end else if (ready0) begin
            n_out = 2'd1;
        end else begin
            n_out = 2'd0;
        end
    end

    // upper instruction only when the word was entered at pc 4 mod 8
    assign n_in = !fill_valid ? 2'd0 : (fill_pc[2] ? 2'd1 : 2'd2);

    always_ff @(posedge clock) begin
        if (!reset) begin
            head  <= 2'd0;
            count <= 3'd0;
        end else if (flush) begin
            count <= 3'd0;
        end else begin
            head  <= head + n_out;
            count <= count + {1'b0, n_in} - {1'b0, n_out};
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid && !flush) begin
            pc_q[tail] <= fill_pc;
            if (fill_pc[2]) begin
                instr_q[tail] <= fill_data[fetch_width-1:ilen];
            end else begin
                instr_q[tail]  <= fill_data[ilen-1:0];  // lower address in the low half
                pc_q[tail1]    <= {fill_pc[xlen-1:3], 3'b100};
                instr_q[tail1] <= fill_data[fetch_width-1:ilen];
            end
        end
    end

endmodule

// File: design/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            trap,
    input  logic [xlen-1:0] mtvec,
    input  logic            mret,
    input  logic [xlen-1:0] mepc,
    input  logic            miss,
    input  logic [xlen-1:0] miss_addr,
    input  logic            fence,
    input  logic [xlen-1:0] fence_npc,
    input  logic            pred0_taken,
    input  logic [xlen-1:0] pred0_target,
    input  logic            pred1_taken,
    input  logic [xlen-1:0] pred1_target,
    input  logic            mem_ready,
    input  logic            full,
    output logic            mem_valid,
    output logic [xlen-1:0] mem_addr,
    output logic            fill_valid,
    output logic [xlen-1:0] fill_pc,
    output logic            flush
);

    fetch_state      state;
    fetch_state      state_n;
    logic [xlen-1:0] pc;      // address of the next request
    logic [xlen-1:0] req_pc;  // address of the request in flight
    logic            pend;    // response still owed by the memory
    logic            waiting;
    logic            redirect;
    logic            fence_sel;
    logic [xlen-1:0] target;

    // fixed redirect priority
    always_comb begin
        redirect  = 1'b1;
        fence_sel = 1'b0;
        target    = pc;
        if (trap) begin
            target = mtvec;
        end else if (mret) begin
            target = mepc;
        end else if (miss) begin
            target = miss_addr;
        end else if (fence) begin
            target    = fence_npc;
            fence_sel = 1'b1;
        end else if (pred0_taken) begin
            target = pred0_target;
        end else if (pred1_taken) begin
            target = pred1_target;
        end else begin
            redirect = 1'b0;
        end
    end

    assign waiting = pend && !mem_ready;

    always_comb begin
        state_n = state;
        case (state)
            idle: begin
                state_n = busy;
            end
            default: begin
                if (!waiting) begin
                    state_n = busy;
                end else if (redirect) begin
                    state_n = fence_sel ? inv : ctrl;  // squash what is in flight
                end
            end
        endcase
    end

    // a new request only once the previous response has been written,
    // so full already accounts for it
    assign mem_valid  = (state == busy) && !pend && !full && !redirect;
    assign mem_addr   = {pc[xlen-1:3], 3'b000};
    assign fill_valid = (state == busy) && mem_ready && !redirect;
    assign fill_pc    = req_pc;
    assign flush      = redirect;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            pend  <= 1'b0;
            pc    <= reset_pc;
        end else begin
            state <= state_n;
            if (mem_valid) begin
                pend <= 1'b1;
            end else if (mem_ready) begin
                pend <= 1'b0;
            end
            if (redirect) begin
                pc <= target;
            end else if (mem_valid) begin
                pc <= {pc[xlen-1:3] + (xlen-3)'(1), 3'b000};  // next aligned word
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_valid) begin
            req_pc <= pc;  // keeps bit 2 for a target that is 4 mod 8
        end
    end

endmodule

// File: design/instr_rom.sv
`timescale 1ns/1ns

module instr_rom import fetch_pkg::*; #(
    parameter int unsigned mem_latency = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   mem_valid,
    input  logic [xlen-1:0]        mem_addr,
    output logic                   mem_ready,
    output logic [fetch_width-1:0] mem_rdata
);

    logic [fetch_width-1:0]    rom [rom_words];
    logic [rom_index_bits-1:0] word_addr;
    logic                      timer_busy;
    logic                      accept;

    initial begin
        $readmemh("program.hex", rom);
    end

    // one request at a time, a second one is refused until the first is answered
    assign accept = mem_valid && !timer_busy;

    mem_wait_timer #(
        .mem_latency(mem_latency)
    ) timer_inst (
        .clock  (clock),
        .reset  (reset),
        .start  (accept),
        .busy   (timer_busy),
        .expired(mem_ready)
    );

    always_ff @(posedge clock) begin
        if (accept) begin
            word_addr <= mem_addr[rom_index_bits+2:3];  // byte address to word index
        end
    end

    assign mem_rdata = rom[word_addr];

endmodule

// File: design/mem_wait_timer.sv
`timescale 1ns/1ns

module mem_wait_timer #(
    parameter int unsigned mem_latency = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic expired
);

    logic [2:0] count;  // latency up to 7
    logic       active;

    assign expired = active && (count == 3'd0);
    // the response cycle itself leaves the memory free for a new request
    assign busy = active && (count != 3'd0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            active <= 1'b0;
            count  <= 3'd0;
        end else if (start) begin
            active <= 1'b1;
            count  <= 3'(mem_latency);
        end else if (expired) begin
            active <= 1'b0;
        end else if (active) begin
            count <= count - 3'd1;
        end
    end

endmodule

// File: design/fetch_pkg.sv
package fetch_pkg;

    // address and data width
    localparam int xlen = 32;

    // one aligned fetch word holds two instructions
    localparam int fetch_width = 64;
    localparam int ilen = fetch_width / 2;

    // instruction memory depth in fetch words
    localparam int rom_words = 16;
    localparam int rom_index_bits = $clog2(rom_words);  // 128 byte window, wraps

    // fetch controller states
    // idle  first cycle out of reset
    // busy  normal fetch, responses go to the buffer
    // ctrl  redirected, squashed response still owed
    // inv   fence, waiting out the in-flight response
    typedef enum logic [1:0] {
        idle = 2'd0,
        busy = 2'd1,
        ctrl = 2'd2,
        inv  = 2'd3
    } fetch_state;

endpackage
